// File: design/pix_pkg.sv
`default_nettype none

package pix_pkg;

	// --------------------
	// Frame geometry
	// --------------------
	localparam int FRAME_W  = 64;                 // Pixels per line
	localparam int FRAME_H  = 48;                 // Lines per frame
	localparam int FB_DEPTH = FRAME_W * FRAME_H;  // 3072 pixels

	// --------------------
	// Vector types
	// --------------------
	typedef logic [11:0] pix_t;       // RGB444, red on top, blue at bottom
	typedef logic [3:0]  nib_t;       // One colour channel
	typedef logic [11:0] fb_addr_t;   // Frame buffer address

	// Last pixel of a frame, where counters wrap
	localparam fb_addr_t FB_LAST_ADR = fb_addr_t'(FB_DEPTH - 1);

	// --------------------
	// Wishbone classic
	// --------------------
	// Master side, toward the slave
	typedef struct packed {
		logic     cyc;
		logic     stb;
		logic     we;   // 1 = write
		fb_addr_t adr;
		pix_t     dat;  // Write data
	} wb_req_t;

	// Slave side, back to the master
	typedef struct packed {
		logic ack;
		pix_t dat;      // Read data, valid with ack
	} wb_rsp_t;

	// --------------------
	// State machines
	// --------------------
	typedef enum logic [0:0] {
		WR_IDLE,        // Waiting for a stage pixel
		WR_BUSY         // Write cycle open on the bus
	} wr_state_t;

	typedef enum logic [1:0] {
		SCAN_IDLE,      // No scan running
		SCAN_READ,      // Bus read in flight
		SCAN_PRESENT    // Pixel on the output stream
	} scan_state_t;

	typedef enum logic [1:0] {
		GNT_NONE,
		GNT_WRITER,
		GNT_READER
	} grant_t;

endpackage

`default_nettype wire

// File: design/pp_greyscale.sv
`timescale 1ns/1ps
`default_nettype none

module pp_greyscale import pix_pkg::*; (
	input  wire  clk_25MHz,
	input  wire  db_rstn,
	input  wire  i_mode,      // 1 = greyscale

	// Upstream pixels
	input  wire  i_valid,
	input  pix_t i_pix,
	input  wire  i_sof,
	output logic o_ready,

	// Downstream pixels
	output logic o_valid,
	output pix_t o_pix,
	output logic o_sof,
	input  wire  i_ready
);

	logic rdy_en;             // Holds ready low for the first cycle out of reset
	logic vld_q;              // Output register full
	pix_t pix_q;
	logic sof_q;
	logic take;               // Input transfer this cycle

	nib_t       red, green, blue;
	logic [5:0] grey_sum;     // r + 2g + b, max 60
	nib_t       grey_lvl;
	pix_t       pix_conv;

	// Accept when empty or being drained this cycle
	assign o_ready = rdy_en && (!vld_q || i_ready);
	assign take    = i_valid && o_ready;

	// --------------------
	// Grey conversion
	// --------------------
	assign red   = i_pix[11:8];
	assign green = i_pix[7:4];
	assign blue  = i_pix[3:0];

	always_comb begin
		grey_sum = {2'b00, red} + {1'b0, green, 1'b0} + {2'b00, blue};
		grey_lvl = grey_sum[5:2];                         // Divide by four, truncate
		pix_conv = i_mode ? {3{grey_lvl}} : i_pix;        // Same level in every channel
	end

	// --------------------
	// Pipeline register
	// --------------------
	always_ff @(posedge clk_25MHz or negedge db_rstn) begin
		if (!db_rstn) begin
			rdy_en <= 1'b0;
			vld_q  <= 1'b0;
		end else begin
			rdy_en <= 1'b1;
			if (take)
				vld_q <= 1'b1;
			else if (i_ready)
				vld_q <= 1'b0;                            // Drained, nothing new
		end
	end

	// Mode sampled together with the pixel
	always_ff @(posedge clk_25MHz) begin
		if (take) begin
			pix_q <= pix_conv;
			sof_q <= i_sof;
		end
	end

	assign o_valid = vld_q;
	assign o_pix   = pix_q;
	assign o_sof   = sof_q;

endmodule

`default_nettype wire

// File: design/frame_writer.sv
`timescale 1ns/1ps
`default_nettype none

module frame_writer import pix_pkg::*; (
	input  wire     clk_25MHz,
	input  wire     db_rstn,

	// Stage pixels in
	input  wire     i_valid,
	input  pix_t    i_pix,
	input  wire     i_sof,
	output logic    o_ready,

	// Wishbone master port
	output wb_req_t o_wb,
	input  wb_rsp_t i_wb
);

	wr_state_t state_q;
	fb_addr_t  nxt_adr_q;     // Address for the next non-sof pixel
	fb_addr_t  cur_adr_q;     // Address of the open write
	pix_t      pix_q;         // Pixel being written
	logic      take;
	logic      wr_busy;

	assign o_ready = (state_q == WR_IDLE);    // One pixel at a time
	assign take    = i_valid && o_ready;
	assign wr_busy = (state_q == WR_BUSY);

	// --------------------
	// Write FSM
	// --------------------
	always_ff @(posedge clk_25MHz or negedge db_rstn) begin
		if (!db_rstn) begin
			state_q   <= WR_IDLE;
			nxt_adr_q <= '0;
			cur_adr_q <= '0;
		end else begin
			case (state_q)
				WR_IDLE: begin
					if (take) begin
						// Frame start restarts at the top of the buffer
						cur_adr_q <= i_sof ? fb_addr_t'(0) : nxt_adr_q;
						state_q   <= WR_BUSY;
					end
				end
				WR_BUSY: begin
					if (i_wb.ack) begin                // Write done, drop cyc next cycle
						state_q <= WR_IDLE;
						if (cur_adr_q == FB_LAST_ADR)
							nxt_adr_q <= '0;                // Wrap at end of frame
						else
							nxt_adr_q <= cur_adr_q + 1'b1;
					end
				end
				default: state_q <= WR_IDLE;
			endcase
		end
	end

	// Pixel held for the whole cycle
	always_ff @(posedge clk_25MHz) begin
		if (take)
			pix_q <= i_pix;
	end

	// --------------------
	// Bus drive
	// --------------------
	assign o_wb = '{
		cyc: wr_busy,
		stb: wr_busy,
		we:  1'b1,           // Writes only
		adr: cur_adr_q,
		dat: pix_q
	};

endmodule

`default_nettype wire

// File: design/scan_reader.sv
`timescale 1ns/1ps
`default_nettype none

module scan_reader import pix_pkg::*; (
	input  wire     clk_25MHz,
	input  wire     db_rstn,
	input  wire     i_start,    // One-cycle scan request

	// Wishbone master port
	output wb_req_t o_wb,
	input  wb_rsp_t i_wb,

	// Scan pixels out
	output logic    o_valid,
	output pix_t    o_pix,
	output logic    o_last,
	input  wire     i_ready,
	output logic    o_busy
);

	scan_state_t state_q;
	fb_addr_t    rd_adr_q;    // Pixel being fetched or shown
	pix_t        pix_q;       // Latched read data
	logic        rd_open;     // Read cycle on the bus
	logic        at_last;

	assign rd_open = (state_q == SCAN_READ);
	assign at_last = (rd_adr_q == FB_LAST_ADR);

	// --------------------
	// Scan FSM
	// --------------------
	always_ff @(posedge clk_25MHz or negedge db_rstn) begin
		if (!db_rstn) begin
			state_q  <= SCAN_IDLE;
			rd_adr_q <= '0;
		end else begin
			case (state_q)
				SCAN_IDLE: begin
					if (i_start) begin               // Start pulse only seen here
						rd_adr_q <= '0;
						state_q  <= SCAN_READ;
					end
				end
				SCAN_READ: begin
					if (i_wb.ack)
						state_q <= SCAN_PRESENT;         // Data latched below
				end
				SCAN_PRESENT: begin
					if (i_ready) begin               // Pixel taken
						if (at_last) begin
							state_q <= SCAN_IDLE;         // Frame done
						end else begin
							rd_adr_q <= rd_adr_q + 1'b1;
							state_q  <= SCAN_READ;
						end
					end
				end
				default: state_q <= SCAN_IDLE;
			endcase
		end
	end

	// Read data arrives with ack
	always_ff @(posedge clk_25MHz) begin
		if (rd_open && i_wb.ack)
			pix_q <= i_wb.dat;
	end

	// --------------------
	// Bus and stream drive
	// --------------------
	assign o_wb = '{
		cyc: rd_open,
		stb: rd_open,
		we:  1'b0,           // Reads only
		adr: rd_adr_q,
		dat: '0
	};

	assign o_valid = (state_q == SCAN_PRESENT);
	assign o_pix   = pix_q;
	assign o_last  = o_valid && at_last;        // Only on pixel FB_DEPTH-1
	assign o_busy  = (state_q != SCAN_IDLE);

endmodule

`default_nettype wire

// File: design/wb_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module wb_arbiter import pix_pkg::*; (
	input  wire     clk_25MHz,
	input  wire     db_rstn,

	// Masters, 0 = writer, 1 = reader
	input  wb_req_t i_m0_req,
	input  wb_req_t i_m1_req,
	output wb_rsp_t o_m0_rsp,
	output wb_rsp_t o_m1_rsp,

	// Shared slave
	output wb_req_t o_s_req,
	input  wb_rsp_t i_s_rsp
);

	grant_t gnt_q;            // Grant held from last cycle
	grant_t gnt_c;            // Grant in force this cycle
	logic   last_rd_q;        // 1 when the reader won last
	logic   hold;
	wb_req_t req_mux;

	// Grant stays while its owner keeps cyc up
	assign hold = (gnt_q == GNT_WRITER && i_m0_req.cyc) ||
	              (gnt_q == GNT_READER && i_m1_req.cyc);

	// --------------------
	// Round robin pick
	// --------------------
	always_comb begin
		gnt_c = GNT_NONE;
		if (hold)
			gnt_c = gnt_q;
		else if (i_m0_req.cyc && i_m1_req.cyc)
			gnt_c = last_rd_q ? GNT_WRITER : GNT_READER;   // Loser of last round wins
		else if (i_m0_req.cyc)
			gnt_c = GNT_WRITER;
		else if (i_m1_req.cyc)
			gnt_c = GNT_READER;
	end

	always_ff @(posedge clk_25MHz or negedge db_rstn) begin
		if (!db_rstn) begin
			gnt_q     <= GNT_NONE;
			last_rd_q <= 1'b0;
		end else begin
			gnt_q <= gnt_c;
			if (gnt_c != GNT_NONE)
				last_rd_q <= (gnt_c == GNT_READER);
		end
	end

	// --------------------
	// Request mux
	// --------------------
	always_comb begin
		req_mux = i_m0_req;
		if (gnt_c == GNT_READER)
			req_mux = i_m1_req;
		if (gnt_c == GNT_NONE) begin
			req_mux.cyc = 1'b0;                         // Idle bus
			req_mux.stb = 1'b0;
		end
	end

	assign o_s_req = req_mux;

	// Ack to the owner only, read data to both
	assign o_m0_rsp = '{ack: i_s_rsp.ack && (gnt_c == GNT_WRITER), dat: i_s_rsp.dat};
	assign o_m1_rsp = '{ack: i_s_rsp.ack && (gnt_c == GNT_READER), dat: i_s_rsp.dat};

endmodule

`default_nettype wire

// File: design/frame_ram.sv
`timescale 1ns/1ps
`default_nettype none

module frame_ram import pix_pkg::*; (
	input  wire     clk_25MHz,
	input  wire     db_rstn,

	// Wishbone slave port
	input  wb_req_t i_wb,
	output wb_rsp_t o_wb
);

	pix_t mem [FB_DEPTH];     // One pixel per entry
	logic ack_q;
	pix_t rdat_q;
	logic access;             // New strobed cycle, not yet acked

	// Ack low on the cycle after each ack, so one ack per cycle
	assign access = i_wb.cyc && i_wb.stb && !ack_q;

	// --------------------
	// Acknowledge
	// --------------------
	always_ff @(posedge clk_25MHz or negedge db_rstn) begin
		if (!db_rstn)
			ack_q <= 1'b0;
		else
			ack_q <= access;                    // Single-cycle pulse
	end

	// --------------------
	// Storage
	// --------------------
	always_ff @(posedge clk_25MHz) begin
		if (access) begin
			if (i_wb.we)
				mem[i_wb.adr] <= i_wb.dat;
			else
				rdat_q <= mem[i_wb.adr];        // Lines up with ack
		end
	end

	assign o_wb = '{ack: ack_q, dat: rdat_q};

endmodule

`default_nettype wire

// File: design/pix_top.sv
`timescale 1ns/1ps
`default_nettype none

module pix_top import pix_pkg::*; (
	input  wire  clk_25MHz,
	input  wire  db_rstn,
	input  wire  i_mode,          // 1 = greyscale

	// Camera pixels in
	input  wire  i_pix_valid,
	input  pix_t i_pix,
	input  wire  i_pix_sof,
	output logic o_pix_ready,

	// Display scan out
	input  wire  i_scan_start,
	input  wire  i_scan_ready,
	output logic o_scan_valid,
	output pix_t o_scan_pix,
	output logic o_scan_last,
	output logic o_scan_busy
);

	// --------------------
	// Internal nets
	// --------------------
	logic    stg_valid;           // Greyscale stage to writer
	pix_t    stg_pix;
	logic    stg_sof;
	logic    stg_ready;

	wb_req_t wr_req;              // Writer master
	wb_rsp_t wr_rsp;
	wb_req_t rd_req;              // Reader master
	wb_rsp_t rd_rsp;
	wb_req_t ram_req;             // Arbiter to memory
	wb_rsp_t ram_rsp;

	// --------------------
	// Pixel path
	// --------------------
	pp_greyscale grey_i (
		.clk_25MHz (clk_25MHz   ),
		.db_rstn   (db_rstn     ),
		.i_mode    (i_mode      ),
		.i_valid   (i_pix_valid ),
		.i_pix     (i_pix       ),
		.i_sof     (i_pix_sof   ),
		.o_ready   (o_pix_ready ),
		.o_valid   (stg_valid   ),
		.o_pix     (stg_pix     ),
		.o_sof     (stg_sof     ),
		.i_ready   (stg_ready   )
	);

	frame_writer writer_i (
		.clk_25MHz (clk_25MHz ),
		.db_rstn   (db_rstn   ),
		.i_valid   (stg_valid ),
		.i_pix     (stg_pix   ),
		.i_sof     (stg_sof   ),
		.o_ready   (stg_ready ),
		.o_wb      (wr_req    ),
		.i_wb      (wr_rsp    )
	);

	scan_reader reader_i (
		.clk_25MHz (clk_25MHz    ),
		.db_rstn   (db_rstn      ),
		.i_start   (i_scan_start ),
		.o_wb      (rd_req       ),
		.i_wb      (rd_rsp       ),
		.o_valid   (o_scan_valid ),
		.o_pix     (o_scan_pix   ),
		.o_last    (o_scan_last  ),
		.i_ready   (i_scan_ready ),
		.o_busy    (o_scan_busy  )
	);

	// --------------------
	// Shared frame buffer
	// --------------------
	wb_arbiter arb_i (
		.clk_25MHz (clk_25MHz ),
		.db_rstn   (db_rstn   ),
		.i_m0_req  (wr_req    ),   // Writer
		.i_m1_req  (rd_req    ),   // Reader
		.o_m0_rsp  (wr_rsp    ),
		.o_m1_rsp  (rd_rsp    ),
		.o_s_req   (ram_req   ),
		.i_s_rsp   (ram_rsp   )
	);

	frame_ram ram_i (
		.clk_25MHz (clk_25MHz ),
		.db_rstn   (db_rstn   ),
		.i_wb      (ram_req   ),
		.o_wb      (ram_rsp   )
	);

endmodule

`default_nettype wire

// File: tests/tb_pix_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_pix_top import pix_pkg::*; ();

	// Generous bound, 8 frames at 16 cycles per pixel
	localparam int TIMEOUT_CYC = 8 * FB_DEPTH * 16;

	logic clk_25MHz;
	logic db_rstn;
	logic i_mode;
	logic i_pix_valid;
	pix_t i_pix;
	logic i_pix_sof;
	logic o_pix_ready;
	logic i_scan_start;
	logic i_scan_ready;
	logic o_scan_valid;
	pix_t o_scan_pix;
	logic o_scan_last;
	logic o_scan_busy;

	integer seed = 37;
	int     errors = 0;
	int     pix_checked = 0;
	int     cycles = 0;

	pix_t model_mem [FB_DEPTH];   // Expected frame contents
	pix_t old_mem [FB_DEPTH];     // Previous frame, for scans racing a write
	int   model_adr = 0;          // Next write address in the model
	int   scan_idx = 0;           // Raster index of the next scan pixel
	logic scan_run = 1'b0;
	logic loose_chk = 1'b0;       // Accept old or new value
	int   stall_cnt = 0;
	int   stall_max = 3;          // Longest ready-low stretch

	pix_top i_dut (
		.clk_25MHz    (clk_25MHz    ),
		.db_rstn      (db_rstn      ),
		.i_mode       (i_mode       ),
		.i_pix_valid  (i_pix_valid  ),
		.i_pix        (i_pix        ),
		.i_pix_sof    (i_pix_sof    ),
		.o_pix_ready  (o_pix_ready  ),
		.i_scan_start (i_scan_start ),
		.i_scan_ready (i_scan_ready ),
		.o_scan_valid (o_scan_valid ),
		.o_scan_pix   (o_scan_pix   ),
		.o_scan_last  (o_scan_last  ),
		.o_scan_busy  (o_scan_busy  )
	);

	always #20 clk_25MHz = ~clk_25MHz;    // 40 ns period

	// --------------------
	// Reference model
	// --------------------
	// Grey level is (r + 2g + b) / 4, copied to all channels
	function automatic pix_t expect_pixel(input pix_t p, input logic grey);
		int   s;
		nib_t lvl;
		s   = int'(p[11:8]) + 2 * int'(p[7:4]) + int'(p[3:0]);
		lvl = nib_t'(s / 4);
		return grey ? {lvl, lvl, lvl} : p;
	endfunction

	task automatic snapshot_model();
		for (int k = 0; k < FB_DEPTH; k++)
			old_mem[k] = model_mem[k];
	endtask

	// Negedge view matches what the next rising edge samples
	always @(negedge clk_25MHz) begin
		int   a;
		pix_t exp_new;
		pix_t exp_old;
		if (db_rstn && i_pix_valid && o_pix_ready) begin
			a            = i_pix_sof ? 0 : model_adr;   // sof restarts the frame
			model_mem[a] = expect_pixel(i_pix, i_mode);
			model_adr    = (a + 1) % FB_DEPTH;
		end
		if (db_rstn && o_scan_valid && i_scan_ready) begin
			assert (scan_run && scan_idx < FB_DEPTH) else begin
				errors++;
				$display("Scan pixel seen outside a running frame scan at %0t ns", $time);
			end
			if (scan_idx < FB_DEPTH) begin
				exp_new = model_mem[scan_idx];
				exp_old = loose_chk ? old_mem[scan_idx] : exp_new;
				assert (o_scan_pix === exp_new || o_scan_pix === exp_old) else begin
					errors++;
					$display("Mismatch at %0t ns: pixel %0d is %h, expected %h (old %h)",
						$time, scan_idx, o_scan_pix, exp_new, exp_old);
				end
				assert (o_scan_last === (scan_idx == FB_DEPTH - 1)) else begin
					errors++;
					$display("Mismatch at %0t ns: last flag %b on pixel %0d",
						$time, o_scan_last, scan_idx);
				end
			end
			scan_idx++;
			pix_checked++;
		end
	end

	// --------------------
	// Stimulus
	// --------------------
	// Random ready, with occasional low stretches
	always @(posedge clk_25MHz) begin
		if (stall_cnt > 0) begin
			stall_cnt    <= stall_cnt - 1;
			i_scan_ready <= 1'b0;
		end else if (($random(seed) & 7) == 0) begin
			stall_cnt    <= $unsigned($random(seed)) % stall_max;
			i_scan_ready <= 1'b0;
		end else begin
			i_scan_ready <= (($random(seed) & 3) != 0);   // Mostly ready
		end
	end

	task automatic send_pixels(input int count, input logic with_sof, input logic mode,
		input int toggle_at);
		int sent;
		sent = 0;
		@(posedge clk_25MHz);
		i_mode <= mode;
		while (sent < count) begin
			if (($random(seed) & 3) == 0) begin       // Valid gap
				i_pix_valid <= 1'b0;
				@(posedge clk_25MHz);
			end
			if (sent == toggle_at)
				i_mode <= !i_mode;                    // Mid-frame mode switch
			i_pix_valid <= 1'b1;
			i_pix       <= pix_t'($random(seed));
			i_pix_sof   <= with_sof && (sent == 0);
			// Hold until the pixel is taken
			do
				@(negedge clk_25MHz);
			while (!o_pix_ready);
			@(posedge clk_25MHz);
			sent++;
		end
		i_pix_valid <= 1'b0;
		i_pix_sof   <= 1'b0;
	endtask

	// Stage empty and writer idle, so the last write is in memory
	task automatic wait_write_idle();
		do
			@(negedge clk_25MHz);
		while (i_dut.stg_valid || !i_dut.stg_ready);
	endtask

	task automatic run_scan(input logic loose);
		@(posedge clk_25MHz);
		scan_idx      = 0;
		loose_chk     = loose;
		i_scan_start <= 1'b1;
		@(posedge clk_25MHz);
		i_scan_start <= 1'b0;
		scan_run      = 1'b1;
		do
			@(negedge clk_25MHz);
		while (o_scan_busy);
		scan_run = 1'b0;
		assert (scan_idx == FB_DEPTH) else begin
			errors++;
			$display("Scan busy dropped after %0d of %0d pixels", scan_idx, FB_DEPTH);
		end
	endtask

	// --------------------
	// Test sequence
	// --------------------
	initial begin
		logic rdy_seen;
		clk_25MHz    = 1'b0;
		db_rstn      = 1'b0;
		i_mode       = 1'b0;
		i_pix_valid  = 1'b0;
		i_pix        = '0;
		i_pix_sof    = 1'b0;
		i_scan_start = 1'b0;
		i_scan_ready = 1'b0;
		for (int k = 0; k < FB_DEPTH; k++)
			model_mem[k] = '0;
		repeat (3) @(posedge clk_25MHz);
		db_rstn <= 1'b1;

		// Reset state
		@(negedge clk_25MHz);
		assert (!o_scan_valid && !o_scan_busy) else begin
			errors++;
			$display("Scan outputs were not idle right after reset");
		end
		rdy_seen = o_pix_ready;
		@(negedge clk_25MHz);
		rdy_seen = rdy_seen || o_pix_ready;
		assert (rdy_seen) else begin
			errors++;
			$display("Input ready did not rise within two cycles of reset");
		end

		// Colour frame
		send_pixels(FB_DEPTH, 1'b1, 1'b0, -1);
		wait_write_idle();
		run_scan(1'b0);

		// Grey frame, switching to colour a third of the way in
		send_pixels(FB_DEPTH, 1'b1, 1'b1, FB_DEPTH / 3);
		wait_write_idle();
		run_scan(1'b0);

		// Two partial frames, tail of the grey frame survives
		send_pixels(1000, 1'b1, 1'b0, -1);
		send_pixels(400, 1'b1, 1'b1, 200);
		wait_write_idle();
		run_scan(1'b0);

		// Scan racing a frame write
		snapshot_model();
		fork
			send_pixels(FB_DEPTH, 1'b1, 1'b0, -1);
			begin
				repeat (200) @(posedge clk_25MHz);
				run_scan(1'b1);
			end
		join
		wait_write_idle();
		run_scan(1'b0);

		// Long back-pressure stretches
		stall_max = 24;
		run_scan(1'b0);

		$display("Tests done: %0d errors, %0d scan pixels checked", errors, pix_checked);
		if (errors == 0)
			$display(">>> PASS");
		else
			$display(">>> FAIL");
		$finish;
	end

	// --------------------
	// Watchdog
	// --------------------
	always @(posedge clk_25MHz) begin
		cycles++;
		if (cycles >= TIMEOUT_CYC) begin
			$display("Timeout: %0d cycles reached before the tests finished", cycles);
			$display(">>> FAIL");
			$finish;
		end
	end

endmodule

`default_nettype wire

// File: verilog.f
design/pix_pkg.sv
design/pp_greyscale.sv
design/frame_writer.sv
design/scan_reader.sv
design/wb_arbiter.sv
design/frame_ram.sv
design/pix_top.sv
tests/tb_pix_top.sv
